// ==== run_verilator.sh ====
#!/usr/bin/env bash
# Build and run the edge-processing testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module cu_graph_edge_tb -f vlog.f --Mdir obj_dir -o sim_cu_graph_edge
if [ $? -ne 0 ]; then
	echo "FAIL: Verilator build did not complete"
	exit 1
fi

# Let the testbench see assertion errors before the run stops
./obj_dir/sim_cu_graph_edge +verilator+error+limit+100 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "Test failed" "$log_file"; then
	echo "FAIL: see $log_file"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "FAIL: simulation exited with status $sim_status"
	exit 1
fi

echo "PASS"
exit 0

// ==== source/cu_edge_data_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cu_edge_data_control (
	input  wire                               clock,
	input  wire                               rstn,
	input  wire                               enabled,
	input  wire cu_pkg::vertex_job_t          vertex_start,
	input  wire cu_pkg::edge_job_t            edge_job,
	output cu_pkg::read_command_t             data_command,
	input  wire cu_pkg::read_response_t       data_response,
	output cu_pkg::edge_data_t                edge_data,
	output logic [cu_pkg::DEGREE_BITS-1:0]    edge_job_counter_pulled,
	output logic                              vertex_done
);

	import cu_pkg::*;

	// Input register
	vertex_job_t vertex_latched;
	edge_job_t   edge_job_latched;

	// Pending queue
	edge_entry_t                 pending_mem [PENDING_DEPTH];
	logic [PENDING_PTR_BITS-1:0] wr_ptr;
	logic [PENDING_PTR_BITS-1:0] issue_ptr;
	logic [PENDING_PTR_BITS-1:0] rd_ptr;
	logic [PENDING_CNT_BITS-1:0] unissued;

	logic                   push_edge;
	logic [DEGREE_BITS-1:0] pulled_next;

	//////////////////////////////////////////////////
	// Input latch
	//////////////////////////////////////////////////

	// Always runs so reads already in flight still land
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_latched   <= '0;
			edge_job_latched <= '0;
		end else begin
			vertex_latched   <= vertex_start;
			edge_job_latched <= edge_job;
		end
	end

	assign push_edge = edge_job_latched.valid;

	//////////////////////////////////////////////////
	// Destination data reads
	//////////////////////////////////////////////////

	// Never refused by the arbiter
	always_comb begin
		data_command.valid   = enabled & (unissued != '0);
		data_command.kind    = READ_DATA;
		data_command.address = pending_mem[issue_ptr].dest_id;
	end

	always_ff @(posedge clock) begin
		if (push_edge) begin
			pending_mem[wr_ptr] <= edge_job_latched.entry;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr    <= '0;
			issue_ptr <= '0;
			rd_ptr    <= '0;
			unissued  <= '0;
		end else begin
			if (push_edge) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (data_command.valid) begin
				issue_ptr <= issue_ptr + 1'b1;
			end
			// Responses pair with the oldest entry
			if (data_response.valid) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_edge, data_command.valid})
				2'b10:   unissued <= unissued + 1'b1;
				2'b01:   unissued <= unissued - 1'b1;
				default: unissued <= unissued;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Edge data and vertex end
	//////////////////////////////////////////////////

	assign pulled_next = edge_job_counter_pulled + 1'b1;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_data               <= '0;
			edge_job_counter_pulled <= '0;
			vertex_done             <= 1'b0;
		end else begin
			vertex_done               <= 1'b0;
			edge_data.valid           <= data_response.valid;
			edge_data.dest_id         <= pending_mem[rd_ptr].dest_id;
			edge_data.weight          <= pending_mem[rd_ptr].weight;
			edge_data.dest_data       <= data_response.data.raw;
			// Vertex with no edges ends at once
			if (vertex_latched.valid && vertex_latched.out_degree == '0) begin
				vertex_done <= 1'b1;
			end
			if (data_response.valid) begin
				if (pulled_next == vertex_latched.out_degree) begin
					edge_job_counter_pulled <= '0;
					vertex_done             <= 1'b1;
				end else begin
					edge_job_counter_pulled <= pulled_next;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/cu_edge_job_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cu_edge_job_control (
	input  wire                         clock,
	input  wire                         rstn,
	input  wire                         enabled,
	input  wire cu_pkg::vertex_job_t    vertex_job,
	output logic                        vertex_busy,
	output cu_pkg::read_command_t       edge_command,
	input  wire                         edge_grant,
	input  wire cu_pkg::read_response_t edge_response,
	output cu_pkg::edge_job_t           edge_job,
	output cu_pkg::vertex_job_t         vertex_start,
	input  wire                         vertex_done
);

	import cu_pkg::*;

	// Accepted vertex, valid is a one-cycle start pulse
	vertex_job_t vertex_q;

	// Edge array walk
	logic [ADDR_BITS-1:0]     edge_addr;
	logic [DEGREE_BITS-1:0]   edges_left;
	logic [INFLIGHT_BITS-1:0] inflight;
	logic [DEGREE_BITS-1:0]   edge_index;

	logic accept;

	assign accept = enabled & vertex_job.valid & ~vertex_busy;

	//////////////////////////////////////////////////
	// Vertex acceptance
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_busy <= 1'b0;
			vertex_q    <= '0;
		end else begin
			vertex_q.valid <= 1'b0;
			if (accept) begin
				vertex_busy <= 1'b1;
				vertex_q    <= vertex_job;
			end else if (vertex_done) begin
				// Last edge data just left the unit
				vertex_busy <= 1'b0;
			end
		end
	end

	assign vertex_start = vertex_q;

	//////////////////////////////////////////////////
	// Edge-entry reads
	//////////////////////////////////////////////////

	// Held until the arbiter takes it
	always_comb begin
		edge_command.valid   = enabled & vertex_busy & (edges_left != '0)
			& (inflight < INFLIGHT_BITS'(EDGE_INFLIGHT_MAX));
		edge_command.kind    = READ_EDGE;
		edge_command.address = edge_addr;
	end

	// Address walk
	always_ff @(posedge clock) begin
		if (accept) begin
			edge_addr <= vertex_job.edge_base;
		end else if (edge_grant) begin
			edge_addr <= edge_addr + 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edges_left <= '0;
			inflight   <= '0;
		end else begin
			if (accept) begin
				edges_left <= vertex_job.out_degree;
			end else if (edge_grant) begin
				edges_left <= edges_left - 1'b1;
			end
			// Reads out, responses back
			case ({edge_grant, edge_response.valid})
				2'b10:   inflight <= inflight + 1'b1;
				2'b01:   inflight <= inflight - 1'b1;
				default: inflight <= inflight;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Edge jobs
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_index <= '0;
			edge_job   <= '0;
		end else begin
			if (accept) begin
				edge_index <= '0;
			end else if (edge_response.valid) begin
				edge_index <= edge_index + 1'b1;
			end
			// Word decoded as an edge entry
			edge_job.valid      <= edge_response.valid;
			edge_job.edge_index <= edge_index;
			edge_job.entry      <= edge_response.data.entry;
		end
	end

endmodule

`default_nettype wire

// ==== source/cu_graph_edge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cu_graph_edge_top (
	input  wire                         clock,
	input  wire                         rstn,
	input  wire                         enabled,
	input  wire cu_pkg::vertex_job_t    vertex_job,
	output logic                        vertex_busy,
	output cu_pkg::read_command_t       mem_command,
	input  wire cu_pkg::read_response_t mem_response,
	output cu_pkg::edge_data_t          edge_data,
	output logic                        vertex_done
);

	import cu_pkg::*;

	// Controller to arbiter
	read_command_t  edge_command;
	read_command_t  data_command;
	logic           edge_grant;
	read_response_t edge_response;
	read_response_t data_response;

	// Job control to data control
	edge_job_t   edge_job;
	vertex_job_t vertex_start;

	//////////////////////////////////////////////////
	// Shared read port
	//////////////////////////////////////////////////

	cu_read_arbiter u_read_arbiter (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.edge_command  (edge_command),
		.data_command  (data_command),
		.edge_grant    (edge_grant),
		.mem_command   (mem_command),
		.mem_response  (mem_response),
		.edge_response (edge_response),
		.data_response (data_response)
	);

	//////////////////////////////////////////////////
	// Controllers
	//////////////////////////////////////////////////

	cu_edge_job_control u_edge_job_control (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.vertex_job    (vertex_job),
		.vertex_busy   (vertex_busy),
		.edge_command  (edge_command),
		.edge_grant    (edge_grant),
		.edge_response (edge_response),
		.edge_job      (edge_job),
		.vertex_start  (vertex_start),
		.vertex_done   (vertex_done)
	);

	// Pulled count stays internal
	cu_edge_data_control u_edge_data_control (
		.clock                   (clock),
		.rstn                    (rstn),
		.enabled                 (enabled),
		.vertex_start            (vertex_start),
		.edge_job                (edge_job),
		.data_command            (data_command),
		.data_response           (data_response),
		.edge_data               (edge_data),
		.edge_job_counter_pulled (),
		.vertex_done             (vertex_done)
	);

endmodule

`default_nettype wire

// ==== source/cu_pkg.sv ====
`default_nettype none

package cu_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	localparam int VERTEX_ID_BITS = 16;
	localparam int ADDR_BITS      = 16;
	localparam int DEGREE_BITS    = 8;
	localparam int DATA_BITS      = 32;
	localparam int WEIGHT_BITS    = 16;

	// Edge-entry reads allowed in flight at once
	localparam int EDGE_INFLIGHT_MAX = 4;
	localparam int INFLIGHT_BITS     = $clog2(EDGE_INFLIGHT_MAX + 1);

	// Jobs waiting for their destination data
	// Room for the in-flight edge reads that still land during a pause
	localparam int PENDING_DEPTH    = 2 * EDGE_INFLIGHT_MAX;
	localparam int PENDING_PTR_BITS = $clog2(PENDING_DEPTH);
	localparam int PENDING_CNT_BITS = $clog2(PENDING_DEPTH + 1);

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////

	// Response routing tag
	typedef enum logic {
		READ_EDGE = 1'b0,
		READ_DATA = 1'b1
	} read_kind_e;

	typedef struct packed {
		logic                      valid;
		logic [VERTEX_ID_BITS-1:0] vertex_id;
		logic [ADDR_BITS-1:0]      edge_base;
		logic [DEGREE_BITS-1:0]    out_degree;
	} vertex_job_t;

	// One edge array entry, exactly one memory word
	typedef struct packed {
		logic [VERTEX_ID_BITS-1:0] dest_id;
		logic [WEIGHT_BITS-1:0]    weight;
	} edge_entry_t;

	// Same word seen as an edge entry or as vertex data
	typedef union packed {
		edge_entry_t          entry;
		logic [DATA_BITS-1:0] raw;
	} mem_word_u;

	typedef struct packed {
		logic                 valid;
		read_kind_e           kind;
		logic [ADDR_BITS-1:0] address;
	} read_command_t;

	typedef struct packed {
		logic       valid;
		read_kind_e kind;
		mem_word_u  data;
	} read_response_t;

	typedef struct packed {
		logic                   valid;
		logic [DEGREE_BITS-1:0] edge_index;
		edge_entry_t            entry;
	} edge_job_t;

	typedef struct packed {
		logic                      valid;
		logic [VERTEX_ID_BITS-1:0] dest_id;
		logic [WEIGHT_BITS-1:0]    weight;
		logic [DATA_BITS-1:0]      dest_data;
	} edge_data_t;

endpackage

`default_nettype wire

// ==== source/cu_read_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cu_read_arbiter (
	input  wire                    clock,
	input  wire                    rstn,
	input  wire                    enabled,
	input  wire cu_pkg::read_command_t  edge_command,
	input  wire cu_pkg::read_command_t  data_command,
	output logic                   edge_grant,
	output cu_pkg::read_command_t  mem_command,
	input  wire cu_pkg::read_response_t mem_response,
	output cu_pkg::read_response_t edge_response,
	output cu_pkg::read_response_t data_response
);

	import cu_pkg::*;

	// Command waiting on the memory port
	read_command_t command_q;

	//////////////////////////////////////////////////
	// Command side
	//////////////////////////////////////////////////

	// Data reads always win
	// Edge read goes only on a free slot
	assign edge_grant = enabled & edge_command.valid & ~data_command.valid;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command_q <= '0;
		end else begin
			// Held while paused so a pending pulse is not lost
			if (enabled) begin
				if (data_command.valid) begin
					command_q <= data_command;
				end else begin
					// Valid low here when nothing asks
					command_q <= edge_command;
				end
			end
		end
	end

	// Hidden while paused, shown again on resume
	always_comb begin
		mem_command       = command_q;
		mem_command.valid = command_q.valid & enabled;
	end

	//////////////////////////////////////////////////
	// Response side
	//////////////////////////////////////////////////

	// In-order memory, kind bit picks the owner
	always_comb begin
		edge_response       = mem_response;
		edge_response.valid = mem_response.valid & (mem_response.kind == READ_EDGE);
		data_response       = mem_response;
		data_response.valid = mem_response.valid & (mem_response.kind == READ_DATA);
	end

endmodule

`default_nettype wire

// ==== test/cu_graph_edge_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module cu_graph_edge_asserts (
	input wire                        clock,
	input wire                        rstn,
	input wire                        enabled,
	input wire                        vertex_busy,
	input wire                        vertex_done,
	input wire cu_pkg::read_command_t mem_command,
	input wire cu_pkg::edge_data_t    edge_data
);

	// One count per property
	int done_fails   = 0;
	int pulse_fails  = 0;
	int paused_fails = 0;
	int idle_fails   = 0;

	logic [31:0] failures;

	assign failures = done_fails + pulse_fails + paused_fails + idle_fails;

	//////////////////////////////////////////////////
	// Vertex end
	//////////////////////////////////////////////////

	done_while_busy: assert property (@(posedge clock) disable iff (!rstn)
		vertex_done |-> vertex_busy)
		else begin
			done_fails++;
			$error("vertex_done pulsed while the unit was idle");
		end

	// Single-cycle pulse
	done_is_pulse: assert property (@(posedge clock) disable iff (!rstn)
		vertex_done |=> !vertex_done)
		else begin
			pulse_fails++;
			$error("vertex_done held for more than one cycle");
		end

	//////////////////////////////////////////////////
	// Memory port and output
	//////////////////////////////////////////////////

	quiet_when_paused: assert property (@(posedge clock) disable iff (!rstn)
		!enabled |-> !mem_command.valid)
		else begin
			paused_fails++;
			$error("memory command issued while enabled was low");
		end

	data_only_when_busy: assert property (@(posedge clock) disable iff (!rstn)
		edge_data.valid |-> vertex_busy)
		else begin
			idle_fails++;
			$error("edge_data valid while the unit was idle");
		end

endmodule

bind cu_graph_edge_top cu_graph_edge_asserts u_asserts (
	.clock       (clock),
	.rstn        (rstn),
	.enabled     (enabled),
	.vertex_busy (vertex_busy),
	.vertex_done (vertex_done),
	.mem_command (mem_command),
	.edge_data   (edge_data)
);

`default_nettype wire

// ==== test/cu_graph_edge_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cu_graph_edge_tb;

	import cu_pkg::*;

	logic           clock;
	logic           rstn;
	logic           enabled;
	vertex_job_t    vertex_job;
	logic           vertex_busy;
	read_command_t  mem_command;
	read_response_t mem_response;
	edge_data_t     edge_data;
	logic           vertex_done;

	// Memory model state
	logic [DATA_BITS-1:0] mem_words [0:65535];
	logic [ADDR_BITS-1:0] pend_addr [$];
	read_kind_e           pend_kind [$];
	int                   pend_due [$];
	int                   latency [0:255];
	logic [7:0]           lat_index = 8'd0;
	int                   last_due = 0;
	int                   cycle = 0;

	// Scoreboard state
	edge_data_t  expected_q [$];
	int          expect_degree;
	int          edges_seen = 0;
	int          done_count = 0;
	int          done_target;
	int          pause_commands = 0;
	logic        pause_active;
	string       test_name;

	cu_graph_edge_top UUT (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.vertex_job   (vertex_job),
		.vertex_busy  (vertex_busy),
		.mem_command  (mem_command),
		.mem_response (mem_response),
		.edge_data    (edge_data),
		.vertex_done  (vertex_done)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Mismatch in %s: %s expected %0h actual %0h",
				test_name, what, expected, actual);
			$display("Test failed");
			$fatal(1, "value check");
		end
	endtask

	task automatic fail_now(input string reason);
		$display("Error in %s: %s", test_name, reason);
		$display("Test failed");
		$fatal(1, "check");
	endtask

	task automatic timeout_fail(input string reason);
		$display("Timeout in %s: %s", test_name, reason);
		$display("Test failed");
		$fatal(1, "timeout");
	endtask

	//////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////

	// Byte-swapped address over a scrambled copy
	task automatic fill_memory();
		int                   a;
		logic [ADDR_BITS-1:0] fill_addr;
		for (a = 0; a < 65536; a++) begin
			fill_addr = 16'(a);
			mem_words[fill_addr] = {fill_addr[7:0], fill_addr[15:8], fill_addr ^ 16'hC3A5};
		end
	endtask

	// In-order responses at most one per cycle
	initial begin : memory_responder
		logic [ADDR_BITS-1:0] addr;
		mem_response = '0;
		forever begin
			@(negedge clock);
			mem_response = '0;
			if (pend_due.size() != 0 && pend_due[0] <= cycle) begin
				addr = pend_addr.pop_front();
				void'(pend_due.pop_front());
				mem_response.valid    = 1'b1;
				mem_response.kind     = pend_kind.pop_front();
				mem_response.data.raw = mem_words[addr];
			end
		end
	end

	//////////////////////////////////////////////////
	// Port monitor and scoreboard
	//////////////////////////////////////////////////

	always @(posedge clock) begin : port_monitor
		int         due;
		edge_data_t expected;
		if (rstn) begin
			cycle = cycle + 1;
			// Accepted command gets 1 to 4 cycles but never passes an older read
			if (mem_command.valid) begin
				due = cycle + latency[lat_index] - 1;
				if (due < last_due)
					due = last_due;
				last_due  = due;
				lat_index = lat_index + 8'd1;
				pend_addr.push_back(mem_command.address);
				pend_kind.push_back(mem_command.kind);
				pend_due.push_back(due);
			end
			if (pause_active && mem_command.valid)
				pause_commands = pause_commands + 1;
			if (edge_data.valid) begin
				if (expected_q.size() == 0) begin
					fail_now("edge_data arrived with no record expected");
				end else begin
					expected = expected_q.pop_front();
					check_value("dest_id", 32'(expected.dest_id), 32'(edge_data.dest_id));
					check_value("weight", 32'(expected.weight), 32'(edge_data.weight));
					check_value("dest_data", expected.dest_data, edge_data.dest_data);
					edges_seen = edges_seen + 1;
				end
			end
			// Last record and the done pulse share a cycle
			if (vertex_done) begin
				check_value("edges before vertex_done", expect_degree, edges_seen);
				edges_seen = 0;
				done_count = done_count + 1;
			end
		end
	end

	// Failure count from the bound port checks
	always @(negedge clock) begin
		if (UUT.u_asserts.failures != 0) begin
			$display("A port assertion fired during %s", test_name);
			$display("Test failed");
			$fatal(1, "port assertion");
		end
	end

	//////////////////////////////////////////////////
	// Vertex stimulus
	//////////////////////////////////////////////////

	task automatic start_vertex(input logic [VERTEX_ID_BITS-1:0] vid,
		input logic [ADDR_BITS-1:0] base, input int degree);
		int                   n;
		int                   i;
		logic [ADDR_BITS-1:0] addr;
		edge_entry_t          entry;
		edge_data_t           rec;
		n = 0;
		while (vertex_busy && n < 200) begin
			@(negedge clock);
			n++;
		end
		if (vertex_busy)
			timeout_fail("unit still busy before a new vertex");
		// Edge arrays sit above 0x8000 and destinations below it
		for (i = 0; i < degree; i++) begin
			addr          = base + 16'(i);
			entry.dest_id = 16'($urandom) & 16'h7FFF;
			entry.weight  = 16'($urandom);
			mem_words[addr] = entry;
			rec.valid     = 1'b1;
			rec.dest_id   = entry.dest_id;
			rec.weight    = entry.weight;
			rec.dest_data = mem_words[entry.dest_id];
			expected_q.push_back(rec);
		end
		expect_degree = degree;
		done_target   = done_count + 1;
		@(negedge clock);
		vertex_job.valid      = 1'b1;
		vertex_job.vertex_id  = vid;
		vertex_job.edge_base  = base;
		vertex_job.out_degree = 8'(degree);
		@(negedge clock);
		vertex_job = '0;
		check_value("vertex_busy after accept", 1, 32'(vertex_busy));
	endtask

	task automatic finish_vertex();
		int n;
		n = 0;
		while (done_count < done_target && n < 1000) begin
			@(negedge clock);
			n++;
		end
		if (done_count < done_target)
			timeout_fail("vertex_done never came");
		check_value("records left after vertex_done", 0, expected_q.size());
		// Busy falls one cycle after the done pulse
		check_value("vertex_busy after vertex_done", 0, 32'(vertex_busy));
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int n;
		int v;
		void'($urandom(32'h6929));
		for (n = 0; n < 256; n++)
			latency[n] = int'($urandom_range(4, 1));
		fill_memory();
		rstn         = 1'b0;
		enabled      = 1'b1;
		vertex_job   = '0;
		pause_active = 1'b0;
		test_name    = "reset_values";
		repeat (10) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		check_value("vertex_busy", 0, 32'(vertex_busy));
		check_value("vertex_done", 0, 32'(vertex_done));
		check_value("mem_command.valid", 0, 32'(mem_command.valid));
		check_value("edge_data.valid", 0, 32'(edge_data.valid));

		test_name = "degree_six";
		start_vertex(16'h0011, 16'h8000, 6);
		finish_vertex();

		test_name = "degree_zero";
		start_vertex(16'h0022, 16'h8080, 0);
		finish_vertex();

		// Pause once two records are out
		test_name = "pause_mid_vertex";
		start_vertex(16'h0033, 16'h8100, 12);
		n = 0;
		while (expected_q.size() > 10 && n < 500) begin
			@(negedge clock);
			n++;
		end
		if (expected_q.size() > 10)
			timeout_fail("first edges of the paused vertex never arrived");
		enabled      = 1'b0;
		pause_active = 1'b1;
		repeat (20) @(negedge clock);
		enabled      = 1'b1;
		pause_active = 1'b0;
		check_value("memory commands while paused", 0, pause_commands);
		finish_vertex();

		test_name = "random_vertices";
		for (v = 0; v < 10; v++) begin
			start_vertex(16'(16'h0100 + v), 16'(16'h8400 + v * 64),
				int'($urandom_range(24, 0)));
			finish_vertex();
		end

		if (expected_q.size() != 0 || pend_due.size() != 0) begin
			$display("Records or memory reads left over at the end of the run");
			$display("Test failed");
			$fatal(1, "leftover state");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/cu_pkg.sv
source/cu_read_arbiter.sv
source/cu_edge_job_control.sv
source/cu_edge_data_control.sv
source/cu_graph_edge_top.sv
test/cu_graph_edge_asserts.sv
test/cu_graph_edge_tb.sv
